//--- Makefile
# Verilator build and run for the timing network node testbench

TOP       ?= tnet_node_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sources.f
tnet_pkg.sv
tnet_cmd_intake.sv
tnet_rx_deframe.sv
tnet_node_ctrl.sv
tnet_tx_frame.sv
tnet_node.sv
tnet_node_assert.sv
tnet_node_tb.sv

//--- tnet_cmd_intake.sv
module tnet_cmd_intake
   import tnet_pkg::*;
(
   input  logic              t_clk,
   input  logic              init_aresetn,
   // Processor port
   input  logic              c_req_i,
   input  logic [CMD_W-1:0]  c_op_i,
   input  logic [DT_W-1:0]   c_dt1_i,
   input  logic [DT_W-1:0]   c_dt2_i,
   input  logic [DT_W-1:0]   c_dt3_i,
   output logic              c_ack_o,
   input  logic [NODE_W-1:0] node_id_i,
   // To node control
   output logic              loc_valid_o,
   input  logic              loc_ready_i,
   output logic [WORD_W-1:0] loc_header_o,
   output logic [WORD_W-1:0] loc_data_o
);

   tnet_header_u hdr;
   logic         op_known;
   logic         new_req;

   assign new_req  = c_req_i && !c_ack_o && !loc_valid_o;
   assign op_known = c_op_i inside {OP_SET_NET, OP_SYNC_NET, OP_UPDT_OFF,
                                    OP_SET_DT, OP_GET_DT};

   // Local header
   always_comb begin
      hdr.raw   = '0;
      hdr.f.cfg = CFG_CMD;
      hdr.f.cmd = c_op_i;
      hdr.f.flg = FLG_LOCAL;
      if (c_op_i == OP_SET_NET || c_op_i == OP_SYNC_NET) begin
         hdr.f.dst = BROADCAST_ADDR;
      end else begin
         hdr.f.dst = c_dt3_i[25:16];
      end
      hdr.f.src = node_id_i;
      hdr.f.id1 = c_dt3_i[9:0];
   end

   // Four-phase handshake
   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         loc_valid_o <= 1'b0;
         c_ack_o     <= 1'b0;
      end else begin
         if (new_req) begin
            if (op_known) begin
               loc_valid_o <= 1'b1;
            end else begin
               // Nothing to send, ack straight away
               c_ack_o <= 1'b1;
            end
         end
         if (loc_valid_o && loc_ready_i) begin
            loc_valid_o <= 1'b0;
            c_ack_o     <= 1'b1;
         end
         if (c_ack_o && !c_req_i) begin
            c_ack_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge t_clk) begin
      if (new_req) begin
         loc_header_o <= hdr.raw;
         loc_data_o   <= {c_dt2_i, c_dt1_i};
      end
   end

endmodule

//--- tnet_node.sv
module tnet_node
   import tnet_pkg::*;
(
   input  logic              t_clk,
   input  logic              init_aresetn,
   // Processor port
   input  logic              c_req_i,
   input  logic [CMD_W-1:0]  c_op_i,
   input  logic [DT_W-1:0]   c_dt1_i,
   input  logic [DT_W-1:0]   c_dt2_i,
   input  logic [DT_W-1:0]   c_dt3_i,
   output logic              c_ack_o,
   // Receive link
   input  logic              rx_valid_i,
   input  logic [WORD_W-1:0] rx_data_i,
   input  logic              rx_last_i,
   // Transmit link
   output logic              tx_valid_o,
   output logic [WORD_W-1:0] tx_data_o,
   output logic              tx_last_o,
   input  logic              tx_ready_i,
   // Time and data
   output logic              time_rst_o,
   output logic              time_init_o,
   output logic              time_updt_o,
   output logic [DT_W-1:0]   time_off_dt_o,
   output logic [DT_W-1:0]   tnet_dt1_o,
   output logic [DT_W-1:0]   tnet_dt2_o
);

   logic              loc_valid;
   logic              loc_ready;
   logic [WORD_W-1:0] loc_header;
   logic [WORD_W-1:0] loc_data;
   logic              net_valid;
   logic              net_ready;
   logic [WORD_W-1:0] net_header;
   logic [WORD_W-1:0] net_data;
   logic              tx_req;
   logic              tx_free;
   logic [WORD_W-1:0] tx_header;
   logic [WORD_W-1:0] tx_data;
   logic [NODE_W-1:0] node_id;

   tnet_cmd_intake u_intake (
      .t_clk        (t_clk),
      .init_aresetn (init_aresetn),
      .c_req_i      (c_req_i),
      .c_op_i       (c_op_i),
      .c_dt1_i      (c_dt1_i),
      .c_dt2_i      (c_dt2_i),
      .c_dt3_i      (c_dt3_i),
      .c_ack_o      (c_ack_o),
      .node_id_i    (node_id),
      .loc_valid_o  (loc_valid),
      .loc_ready_i  (loc_ready),
      .loc_header_o (loc_header),
      .loc_data_o   (loc_data)
   );

   tnet_rx_deframe u_deframe (
      .t_clk        (t_clk),
      .init_aresetn (init_aresetn),
      .rx_valid_i   (rx_valid_i),
      .rx_data_i    (rx_data_i),
      .rx_last_i    (rx_last_i),
      .net_valid_o  (net_valid),
      .net_ready_i  (net_ready),
      .net_header_o (net_header),
      .net_data_o   (net_data)
   );

   tnet_node_ctrl u_ctrl (
      .t_clk         (t_clk),
      .init_aresetn  (init_aresetn),
      .loc_valid_i   (loc_valid),
      .loc_ready_o   (loc_ready),
      .loc_header_i  (loc_header),
      .loc_data_i    (loc_data),
      .net_valid_i   (net_valid),
      .net_ready_o   (net_ready),
      .net_header_i  (net_header),
      .net_data_i    (net_data),
      .tx_req_o      (tx_req),
      .tx_free_i     (tx_free),
      .tx_header_o   (tx_header),
      .tx_data_o     (tx_data),
      .node_id_o     (node_id),
      .time_rst_o    (time_rst_o),
      .time_init_o   (time_init_o),
      .time_updt_o   (time_updt_o),
      .time_off_dt_o (time_off_dt_o),
      .tnet_dt1_o    (tnet_dt1_o),
      .tnet_dt2_o    (tnet_dt2_o)
   );

   tnet_tx_frame u_tx (
      .t_clk        (t_clk),
      .init_aresetn (init_aresetn),
      .tx_req_i     (tx_req),
      .tx_free_o    (tx_free),
      .tx_header_i  (tx_header),
      .tx_data_i    (tx_data),
      .tx_valid_o   (tx_valid_o),
      .tx_data_o    (tx_data_o),
      .tx_last_o    (tx_last_o),
      .tx_ready_i   (tx_ready_i)
   );

endmodule

//--- tnet_node_assert.sv
module tnet_node_assert
   import tnet_pkg::*;
(
   input logic              t_clk,
   input logic              init_aresetn,
   input logic              c_req_i,
   input logic              c_ack_o,
   input logic              tx_valid_o,
   input logic [WORD_W-1:0] tx_data_o,
   input logic              tx_last_o,
   input logic              tx_ready_i
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   // Beat stays put until the link takes it
   a_tx_hold: assert property (@(posedge t_clk) disable iff (!init_aresetn)
      tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o) && $stable(tx_last_o))
   else begin
      $error("tx beat changed while tx_ready_i was low");
      fail_count++;
   end

   a_last_valid: assert property (@(posedge t_clk) disable iff (!init_aresetn)
      tx_last_o |-> tx_valid_o)
   else begin
      $error("tx_last_o high without tx_valid_o");
      fail_count++;
   end

   // Ack only answers a live request
   a_ack_rise: assert property (@(posedge t_clk) disable iff (!init_aresetn)
      !c_req_i |=> !$rose(c_ack_o))
   else begin
      $error("c_ack_o rose while c_req_i was low");
      fail_count++;
   end

endmodule

bind tnet_node tnet_node_assert u_assert (
   .t_clk        (t_clk),
   .init_aresetn (init_aresetn),
   .c_req_i      (c_req_i),
   .c_ack_o      (c_ack_o),
   .tx_valid_o   (tx_valid_o),
   .tx_data_o    (tx_data_o),
   .tx_last_o    (tx_last_o),
   .tx_ready_i   (tx_ready_i)
);

//--- tnet_node_ctrl.sv
module tnet_node_ctrl
   import tnet_pkg::*;
(
   input  logic              t_clk,
   input  logic              init_aresetn,
   // Local commands
   input  logic              loc_valid_i,
   output logic              loc_ready_o,
   input  logic [WORD_W-1:0] loc_header_i,
   input  logic [WORD_W-1:0] loc_data_i,
   // Network commands
   input  logic              net_valid_i,
   output logic              net_ready_o,
   input  logic [WORD_W-1:0] net_header_i,
   input  logic [WORD_W-1:0] net_data_i,
   // To transmit
   output logic              tx_req_o,
   input  logic              tx_free_i,
   output logic [WORD_W-1:0] tx_header_o,
   output logic [WORD_W-1:0] tx_data_o,
   // Node state
   output logic [NODE_W-1:0] node_id_o,
   output logic              time_rst_o,
   output logic              time_init_o,
   output logic              time_updt_o,
   output logic [DT_W-1:0]   time_off_dt_o,
   output logic [DT_W-1:0]   tnet_dt1_o,
   output logic [DT_W-1:0]   tnet_dt2_o
);

   tnet_header_u      in_h;
   tnet_header_u      out_h;
   logic [WORD_W-1:0] in_d;
   logic [WORD_W-1:0] out_d;
   logic [DT_W-1:0]   dt1;
   logic [DT_W-1:0]   dt2;
   logic              rdy;
   logic              take;
   logic              to_me;
   logic              send;
   logic              upd_net;
   logic              upd_off;
   logic              upd_dt;
   logic [DT_W-1:0]   off_new;
   logic              do_init;
   logic              do_updt;
   logic              do_rst;

   logic [NODE_W-1:0] param_id;
   logic [DT_W-1:0]   param_cd;

   // One command in flight towards tx at a time, local first
   assign rdy         = tx_free_i && !tx_req_o;
   assign loc_ready_o = rdy;
   assign net_ready_o = rdy && !loc_valid_i;
   assign take        = rdy && (loc_valid_i || net_valid_i);

   ////////////////////
   // Command decode

   always_comb begin
      in_h.raw = loc_valid_i ? loc_header_i : net_header_i;
      in_d     = loc_valid_i ? loc_data_i : net_data_i;
      dt1      = in_d[DT_W-1:0];
      dt2      = in_d[WORD_W-1:DT_W];
      to_me    = (in_h.f.dst == param_id);
      out_h    = in_h;
      out_d    = in_d;
      send     = 1'b0;
      upd_net  = 1'b0;
      upd_off  = 1'b0;
      upd_dt   = 1'b0;
      off_new  = dt1;
      do_init  = 1'b0;
      do_updt  = 1'b0;
      do_rst   = 1'b0;
      if (loc_valid_i) begin
         send   = 1'b1;
         // Node starts a new network setup or sync
         do_rst = (in_h.f.cmd == OP_SET_NET) || (in_h.f.cmd == OP_SYNC_NET);
      end else begin
         case (in_h.f.cmd)
            OP_SET_NET: begin
               upd_net   = 1'b1;
               out_h.raw = in_h.raw + 1'b1;
               send      = 1'b1;
            end
            OP_SYNC_NET: begin
               upd_off          = 1'b1;
               off_new          = dt1 + dt2;
               do_init          = 1'b1;
               out_d[DT_W-1:0]  = dt1 + param_cd;
               send             = 1'b1;
            end
            OP_UPDT_OFF: begin
               send    = 1'b1;
               upd_off = to_me;
               do_updt = to_me;
            end
            OP_SET_DT: begin
               send   = 1'b1;
               upd_dt = to_me;
            end
            OP_GET_DT: begin
               send = 1'b1;
               if (to_me) begin
                  out_h.raw   = '0;
                  out_h.f.cfg = CFG_CMD;
                  out_h.f.cmd = OP_GET_DT;
                  out_h.f.flg = FLG_ANSWER;
                  out_h.f.dst = in_h.f.src;
                  out_h.f.src = param_id;
                  out_h.f.id1 = in_h.f.id1;
                  out_d       = {tnet_dt2_o, tnet_dt1_o};
               end
            end
            default: ;
         endcase
      end
   end

   ////////////////////
   // Parameters and pulses

   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         tx_req_o      <= 1'b0;
         time_rst_o    <= 1'b0;
         time_init_o   <= 1'b0;
         time_updt_o   <= 1'b0;
         param_id      <= '0;
         param_cd      <= '0;
         time_off_dt_o <= '0;
         tnet_dt1_o    <= '0;
         tnet_dt2_o    <= '0;
      end else begin
         tx_req_o    <= (tx_req_o && !tx_free_i) || (take && send);
         time_rst_o  <= take && do_rst;
         time_init_o <= take && do_init;
         time_updt_o <= take && do_updt;
         if (take && upd_net) begin
            param_id <= in_h.f.id1;
            param_cd <= dt1;
         end
         if (take && upd_off) time_off_dt_o <= off_new;
         if (take && upd_dt) begin
            tnet_dt1_o <= dt1;
            tnet_dt2_o <= dt2;
         end
      end
   end

   always_ff @(posedge t_clk) begin
      if (take) begin
         tx_header_o <= out_h.raw;
         tx_data_o   <= out_d;
      end
   end

   assign node_id_o = param_id;

endmodule

//--- tnet_node_tb.sv
module tnet_node_tb
   import tnet_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int TIMEOUT = 500;

   logic              t_clk = 1'b0;
   logic              init_aresetn;
   logic              c_req_i;
   logic [CMD_W-1:0]  c_op_i;
   logic [DT_W-1:0]   c_dt1_i;
   logic [DT_W-1:0]   c_dt2_i;
   logic [DT_W-1:0]   c_dt3_i;
   logic              c_ack_o;
   logic              rx_valid_i;
   logic [WORD_W-1:0] rx_data_i;
   logic              rx_last_i;
   logic              tx_valid_o;
   logic [WORD_W-1:0] tx_data_o;
   logic              tx_last_o;
   logic              tx_ready_i = 1'b1;
   logic              time_rst_o;
   logic              time_init_o;
   logic              time_updt_o;
   logic [DT_W-1:0]   time_off_dt_o;
   logic [DT_W-1:0]   tnet_dt1_o;
   logic [DT_W-1:0]   tnet_dt2_o;

   // Node model
   logic [NODE_W-1:0] m_id = '0;
   logic [DT_W-1:0]   m_cd = '0;
   logic [DT_W-1:0]   m_off = '0;
   logic [DT_W-1:0]   m_dt1 = '0;
   logic [DT_W-1:0]   m_dt2 = '0;
   int                exp_init = 0;
   int                exp_updt = 0;
   int                exp_rst = 0;
   int                got_init = 0;
   int                got_updt = 0;
   int                got_rst = 0;
   logic [WORD_W-1:0] exp_hdr_q[$];
   logic [WORD_W-1:0] exp_dat_q[$];
   logic [WORD_W-1:0] got_hdr;
   int                frame_no = 0;
   int                value_errors = 0;
   int                other_errors = 0;
   logic [31:0]       pay_lfsr = 32'h08a09257;
   logic [31:0]       stall_lfsr = 32'h08a09257;
   logic              stall_en = 1'b0;

   tnet_node tnet_node_i (.*);

   always #5 t_clk = ~t_clk;

   ////////////////////
   // Random source

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [WORD_W-1:0] rand_bits(input int n);
      logic [WORD_W-1:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         pay_lfsr = lfsr_next(pay_lfsr);
         v = {v[WORD_W-2:0], pay_lfsr[0]};
      end
      return v;
   endfunction

   ////////////////////
   // Reference

   function automatic tnet_header_u make_header(input logic [CMD_W-1:0] op,
      input logic [NODE_W-1:0] dst, input logic [NODE_W-1:0] src,
      input logic [NODE_W-1:0] id0, input logic [NODE_W-1:0] id1);
      tnet_header_u h;
      h.raw   = '0;
      h.f.cfg = CFG_CMD;
      h.f.cmd = op;
      h.f.dst = dst;
      h.f.src = src;
      h.f.id0 = id0;
      h.f.id1 = id1;
      return h;
   endfunction

   // Header the processor port should produce
   function automatic tnet_header_u local_header(input logic [CMD_W-1:0] op,
      input logic [DT_W-1:0] dt3, input logic [NODE_W-1:0] id);
      tnet_header_u h;
      if (op == OP_SET_NET || op == OP_SYNC_NET) begin
         h = make_header(op, BROADCAST_ADDR, id, '0, dt3[9:0]);
      end else begin
         h = make_header(op, dt3[25:16], id, '0, dt3[9:0]);
      end
      h.f.flg = FLG_LOCAL;
      return h;
   endfunction

   function automatic logic expect_cmd(
      input  logic              is_loc,
      input  tnet_header_u      h,
      input  logic [WORD_W-1:0] d,
      inout  logic [NODE_W-1:0] id,
      inout  logic [DT_W-1:0]   cd,
      inout  logic [DT_W-1:0]   off,
      inout  logic [DT_W-1:0]   sdt1,
      inout  logic [DT_W-1:0]   sdt2,
      inout  int                n_init,
      inout  int                n_updt,
      inout  int                n_rst,
      output tnet_header_u      eh,
      output logic [WORD_W-1:0] ed
   );
      logic [DT_W-1:0] dt1;
      logic [DT_W-1:0] dt2;
      logic            hit;
      logic            send;
      dt1  = d[DT_W-1:0];
      dt2  = d[WORD_W-1:DT_W];
      hit  = (h.f.dst == id);
      eh   = h;
      ed   = d;
      send = 1'b1;
      if (is_loc) begin
         if (h.f.cmd == OP_SET_NET || h.f.cmd == OP_SYNC_NET) n_rst++;
      end else begin
         case (h.f.cmd)
            OP_SET_NET: begin
               id     = h.f.id1;
               cd     = dt1;
               eh.raw = h.raw + 64'd1;
            end
            OP_SYNC_NET: begin
               off             = dt1 + dt2;
               n_init++;
               ed[DT_W-1:0]    = dt1 + cd;
            end
            OP_UPDT_OFF: begin
               if (hit) begin
                  off = dt1;
                  n_updt++;
               end
            end
            OP_SET_DT: begin
               if (hit) begin
                  sdt1 = dt1;
                  sdt2 = dt2;
               end
            end
            OP_GET_DT: begin
               if (hit) begin
                  eh       = make_header(OP_GET_DT, h.f.src, id, '0, h.f.id1);
                  eh.f.flg = FLG_ANSWER;
                  ed       = {sdt2, sdt1};
               end
            end
            default: send = 1'b0;
         endcase
      end
      return send;
   endfunction

   ////////////////////
   // Checks

   task automatic check_header(input string name, input tnet_header_u exp,
      input tnet_header_u act);
      if (act.raw !== exp.raw) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp.raw, act.raw);
         value_errors++;
      end
   endtask

   task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
      input logic [WORD_W-1:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_dt(input string name, input logic [DT_W-1:0] exp,
      input logic [DT_W-1:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_state(input string name);
      check_dt({name, " time_off_dt"}, m_off, time_off_dt_o);
      check_dt({name, " tnet_dt1"}, m_dt1, tnet_dt1_o);
      check_dt({name, " tnet_dt2"}, m_dt2, tnet_dt2_o);
      check_count({name, " init pulses"}, exp_init, got_init);
      check_count({name, " updt pulses"}, exp_updt, got_updt);
      check_count({name, " rst pulses"}, exp_rst, got_rst);
   endtask

   ////////////////////
   // Stimulus

   task automatic push_expected(input logic is_loc, input tnet_header_u h,
      input logic [WORD_W-1:0] d);
      tnet_header_u      eh;
      logic [WORD_W-1:0] ed;
      if (expect_cmd(is_loc, h, d, m_id, m_cd, m_off, m_dt1, m_dt2,
                     exp_init, exp_updt, exp_rst, eh, ed)) begin
         exp_hdr_q.push_back(eh.raw);
         exp_dat_q.push_back(ed);
      end
   endtask

   task automatic send_net(input tnet_header_u h, input logic [WORD_W-1:0] d);
      push_expected(1'b0, h, d);
      @(negedge t_clk);
      rx_valid_i = 1'b1;
      rx_data_i  = h.raw;
      rx_last_i  = 1'b0;
      @(negedge t_clk);
      rx_data_i  = d;
      rx_last_i  = 1'b1;
      @(negedge t_clk);
      rx_valid_i = 1'b0;
      rx_last_i  = 1'b0;
   endtask

   task automatic do_local(input logic [CMD_W-1:0] op, input logic [WORD_W-1:0] d,
      input logic [DT_W-1:0] dt3);
      int n;
      if (op inside {OP_SET_NET, OP_SYNC_NET, OP_UPDT_OFF, OP_SET_DT, OP_GET_DT}) begin
         push_expected(1'b1, local_header(op, dt3, m_id), d);
      end
      @(negedge t_clk);
      c_op_i  = op;
      c_dt1_i = d[DT_W-1:0];
      c_dt2_i = d[WORD_W-1:DT_W];
      c_dt3_i = dt3;
      c_req_i = 1'b1;
      n = 0;
      while (!c_ack_o && n < TIMEOUT) begin
         @(negedge t_clk);
         n++;
      end
      if (!c_ack_o) begin
         $display("Timeout waiting for c_ack_o to rise");
         other_errors++;
      end
      c_req_i = 1'b0;
      n = 0;
      while (c_ack_o && n < TIMEOUT) begin
         @(negedge t_clk);
         n++;
      end
      if (c_ack_o) begin
         $display("Timeout waiting for c_ack_o to fall");
         other_errors++;
      end
   endtask

   // Every expected frame out and the link quiet
   task automatic wait_idle();
      int n;
      n = 0;
      while ((exp_hdr_q.size() != 0 || tx_valid_o) && n < TIMEOUT) begin
         @(negedge t_clk);
         n++;
      end
      if (n >= TIMEOUT) begin
         $display("Timeout waiting for %0d expected frames", exp_hdr_q.size());
         other_errors++;
      end
   endtask

   always @(negedge t_clk) begin
      if (stall_en) begin
         stall_lfsr = lfsr_next(stall_lfsr);
         tx_ready_i = stall_lfsr[0];
      end else begin
         tx_ready_i = 1'b1;
      end
   end

   ////////////////////
   // Monitors

   always @(posedge t_clk) begin
      if (init_aresetn) begin
         if (time_init_o) got_init++;
         if (time_updt_o) got_updt++;
         if (time_rst_o) got_rst++;
      end
   end

   always @(posedge t_clk) begin
      if (init_aresetn && tx_valid_o && tx_ready_i) begin
         if (!tx_last_o) begin
            got_hdr = tx_data_o;
         end else if (exp_hdr_q.size() == 0) begin
            $display("Unexpected frame on the tx link with header %h", got_hdr);
            other_errors++;
         end else begin
            check_header($sformatf("frame %0d header", frame_no), exp_hdr_q.pop_front(),
                         got_hdr);
            check_word($sformatf("frame %0d data", frame_no), exp_dat_q.pop_front(),
                       tx_data_o);
            frame_no++;
         end
      end
   end

   initial begin
      tnet_header_u      h;
      logic [WORD_W-1:0] w;
      logic [WORD_W-1:0] d;
      int                asrt;
      init_aresetn = 1'b0;
      c_req_i      = 1'b0;
      c_op_i       = '0;
      c_dt1_i      = '0;
      c_dt2_i      = '0;
      c_dt3_i      = '0;
      rx_valid_i   = 1'b0;
      rx_data_i    = '0;
      rx_last_i    = 1'b0;
      repeat (16) @(negedge t_clk);
      init_aresetn = 1'b1;
      @(negedge t_clk);

      check_bit("reset tx_valid_o", 1'b0, tx_valid_o);
      check_bit("reset c_ack_o", 1'b0, c_ack_o);
      check_bit("reset time_init_o", 1'b0, time_init_o);
      check_bit("reset time_updt_o", 1'b0, time_updt_o);
      check_bit("reset time_rst_o", 1'b0, time_rst_o);
      check_state("reset");

      // Network setup, then a local command carrying the new ID
      w = rand_bits(NODE_W);
      send_net(make_header(OP_SET_NET, BROADCAST_ADDR, 10'd5, 10'd8, w[NODE_W-1:0]),
               rand_bits(WORD_W));
      wait_idle();
      do_local(OP_SET_DT, rand_bits(WORD_W), {6'd0, 10'h155, 6'd0, 10'h0a3});
      do_local(OP_SYNC_NET, rand_bits(WORD_W), 32'h0000_0011);
      wait_idle();
      check_state("set_net");

      send_net(make_header(OP_SYNC_NET, BROADCAST_ADDR, 10'd3, '0, '0), rand_bits(WORD_W));
      wait_idle();
      check_state("sync_net");

      // Addressed here, then elsewhere
      send_net(make_header(OP_UPDT_OFF, m_id, 10'd2, '0, 10'd7), rand_bits(WORD_W));
      send_net(make_header(OP_SET_DT, m_id, 10'd2, '0, 10'd9), rand_bits(WORD_W));
      wait_idle();
      check_state("updt_off set_dt here");
      send_net(make_header(OP_UPDT_OFF, m_id ^ 10'd1, 10'd2, '0, 10'd7), rand_bits(WORD_W));
      send_net(make_header(OP_SET_DT, m_id ^ 10'd1, 10'd2, '0, 10'd9), rand_bits(WORD_W));
      wait_idle();
      check_state("updt_off set_dt elsewhere");

      send_net(make_header(OP_GET_DT, m_id, 10'h1c2, '0, 10'h02c), rand_bits(WORD_W));
      wait_idle();
      send_net(make_header(5'b11111, m_id, 10'd4, '0, '0), rand_bits(WORD_W));
      do_local(5'b00111, rand_bits(WORD_W), '0);
      send_net(make_header(OP_GET_DT, m_id ^ 10'd1, 10'd6, '0, 10'd1), rand_bits(WORD_W));
      wait_idle();
      check_state("get_dt");

      // Pairs of frames under random back-pressure
      stall_en = 1'b1;
      repeat (24) begin
         repeat (2) begin
            w = rand_bits(3);
            d = rand_bits(WORD_W);
            case (w[1:0])
               2'd0:    h = make_header(OP_SYNC_NET, BROADCAST_ADDR, 10'd7, '0, '0);
               2'd1:    h = make_header(OP_UPDT_OFF, m_id ^ {9'd0, w[2]}, 10'd7, '0, '0);
               2'd2:    h = make_header(OP_SET_DT, m_id ^ {9'd0, w[2]}, 10'd7, '0, '0);
               default: h = make_header(OP_GET_DT, m_id ^ {9'd0, w[2]}, 10'd7, '0, d[9:0]);
            endcase
            send_net(h, d);
         end
         wait_idle();
      end
      stall_en = 1'b0;
      wait_idle();
      check_state("stalls");

      asrt = tnet_node_i.u_assert.fail_count;
      $display("Errors: %0d value mismatches, %0d other failures, %0d assertion failures",
               value_errors, other_errors, asrt);
      if (value_errors == 0 && other_errors == 0 && asrt == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- tnet_pkg.sv
package tnet_pkg;

   ////////////////////
   // Opcodes

   localparam int CMD_W = 5;

   localparam logic [CMD_W-1:0] OP_SET_NET  = 5'b00010;
   localparam logic [CMD_W-1:0] OP_SYNC_NET = 5'b01000;
   localparam logic [CMD_W-1:0] OP_UPDT_OFF = 5'b01001;
   localparam logic [CMD_W-1:0] OP_SET_DT   = 5'b01010;
   localparam logic [CMD_W-1:0] OP_GET_DT   = 5'b01011;

   ////////////////////
   // Field widths

   localparam int CFG_W  = 3;
   localparam int FLG_W  = 6;
   localparam int NODE_W = 10;
   localparam int DT_W   = 32;
   localparam int WORD_W = 64;

   ////////////////////
   // Header constants

   localparam logic [NODE_W-1:0] BROADCAST_ADDR = '1;
   localparam logic [CFG_W-1:0]  CFG_CMD        = 3'b100;

   // Flags, one bit per meaning
   localparam logic [FLG_W-1:0] FLG_LOCAL  = 6'b000100;
   localparam logic [FLG_W-1:0] FLG_ANSWER = 6'b000001;

   ////////////////////
   // Command header word

   // Raw view is what forwarding counts on, field view is what decode reads
   typedef union packed {
      logic [WORD_W-1:0] raw;
      struct packed {
         logic [CFG_W-1:0]  cfg;
         logic [CMD_W-1:0]  cmd;
         logic [FLG_W-1:0]  flg;
         logic [NODE_W-1:0] dst;
         logic [NODE_W-1:0] src;
         logic [NODE_W-1:0] step;
         logic [NODE_W-1:0] id0;
         // Lowest field, so raw plus one lands here
         logic [NODE_W-1:0] id1;
      } f;
   } tnet_header_u;

endpackage

//--- tnet_rx_deframe.sv
module tnet_rx_deframe
   import tnet_pkg::*;
(
   input  logic              t_clk,
   input  logic              init_aresetn,
   // Receive link
   input  logic              rx_valid_i,
   input  logic [WORD_W-1:0] rx_data_i,
   input  logic              rx_last_i,
   // To node control
   output logic              net_valid_o,
   input  logic              net_ready_i,
   output logic [WORD_W-1:0] net_header_o,
   output logic [WORD_W-1:0] net_data_o
);

   logic              hdr_v;
   logic              full_r;
   logic [WORD_W-1:0] hdr_r;
   logic [WORD_W-1:0] dat_r;
   logic              hdr_beat;
   logic              last_hit;
   logic              out_free;

   assign hdr_beat = rx_valid_i && !rx_last_i;
   // Data beat with no header is ignored
   assign last_hit = rx_valid_i && rx_last_i && hdr_v;
   assign out_free = !net_valid_o || net_ready_i;

   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         hdr_v       <= 1'b0;
         full_r      <= 1'b0;
         net_valid_o <= 1'b0;
      end else begin
         if (hdr_beat) hdr_v <= 1'b1;
         if (last_hit) hdr_v <= 1'b0;
         if (net_valid_o && net_ready_i) net_valid_o <= 1'b0;
         // Second frame waits in the assembly registers
         if (full_r && out_free) begin
            net_valid_o <= 1'b1;
            full_r      <= 1'b0;
         end
         if (last_hit) begin
            if (out_free) net_valid_o <= 1'b1;
            else          full_r      <= 1'b1;
         end
      end
   end

   always_ff @(posedge t_clk) begin
      if (hdr_beat) hdr_r <= rx_data_i;
      if (last_hit) dat_r <= rx_data_i;
      if (out_free && (full_r || last_hit)) begin
         net_header_o <= hdr_r;
         net_data_o   <= full_r ? dat_r : rx_data_i;
      end
   end

endmodule

//--- tnet_tx_frame.sv
module tnet_tx_frame
   import tnet_pkg::*;
(
   input  logic              t_clk,
   input  logic              init_aresetn,
   // From node control
   input  logic              tx_req_i,
   output logic              tx_free_o,
   input  logic [WORD_W-1:0] tx_header_i,
   input  logic [WORD_W-1:0] tx_data_i,
   // Transmit link
   output logic              tx_valid_o,
   output logic [WORD_W-1:0] tx_data_o,
   output logic              tx_last_o,
   input  logic              tx_ready_i
);

   logic [WORD_W-1:0] hdr_r;
   logic [WORD_W-1:0] dat_r;
   logic              load;

   assign tx_free_o = !tx_valid_o;
   assign load      = tx_req_i && tx_free_o;

   // Header beat first, then data beat with last
   always_ff @(posedge t_clk or negedge init_aresetn) begin
      if (!init_aresetn) begin
         tx_valid_o <= 1'b0;
         tx_last_o  <= 1'b0;
      end else begin
         if (load) begin
            tx_valid_o <= 1'b1;
            tx_last_o  <= 1'b0;
         end else if (tx_valid_o && tx_ready_i) begin
            if (tx_last_o) begin
               tx_valid_o <= 1'b0;
               tx_last_o  <= 1'b0;
            end else begin
               tx_last_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge t_clk) begin
      if (load) begin
         hdr_r <= tx_header_i;
         dat_r <= tx_data_i;
      end
   end

   assign tx_data_o = tx_last_o ? dat_r : hdr_r;

endmodule
